//--- build.f
rtl/fetch_pkg.sv
rtl/fetch_outstanding_fifo.sv
rtl/branch_target_buffer.sv
rtl/fetch_unit.sv
rtl/insn_fetch_top.sv
verification/tb_ibus_memory.sv
verification/tb_insn_fetch.sv

//--- rtl/branch_target_buffer.sv
// Direct-mapped branch predictor: combinational lookup by fetch PC, trained through a write port
`timescale 1ns/1ps
`default_nettype none

module branch_target_buffer (
   input  wire                 clk,
   input  wire                 rst_n,
   // Lookup by the current fetch PC
   input  wire fetch_pkg::pc_t lookup_pc,
   output logic                pred_taken,
   output fetch_pkg::pc_t      pred_tgt,
   // Training from execute
   input  wire                 update,
   input  wire fetch_pkg::pc_t update_pc,
   input  wire fetch_pkg::pc_t update_tgt,
   input  wire                 update_taken
);

   // Per-entry valid, taken, tag and target
   logic [fetch_pkg::BTB_ENTRIES-1:0] valid;
   logic [fetch_pkg::BTB_ENTRIES-1:0] taken;
   logic [fetch_pkg::BTB_TAG_W-1:0]   tag [fetch_pkg::BTB_ENTRIES];
   fetch_pkg::pc_t                    tgt [fetch_pkg::BTB_ENTRIES];

   logic [fetch_pkg::BTB_INDEX_W-1:0] lookup_idx;
   logic [fetch_pkg::BTB_TAG_W-1:0]   lookup_tag;
   logic [fetch_pkg::BTB_INDEX_W-1:0] update_idx;
   logic [fetch_pkg::BTB_TAG_W-1:0]   update_tag;
   logic                              hit;

   // Low PC bits pick the entry, upper bits form the tag
   assign lookup_idx = lookup_pc[fetch_pkg::BTB_INDEX_W-1:0];
   assign lookup_tag = lookup_pc[fetch_pkg::PC_W-1:fetch_pkg::BTB_INDEX_W];
   assign update_idx = update_pc[fetch_pkg::BTB_INDEX_W-1:0];
   assign update_tag = update_pc[fetch_pkg::PC_W-1:fetch_pkg::BTB_INDEX_W];

   // Entry belongs to this PC only if valid and tags agree
   assign hit = valid[lookup_idx] & (tag[lookup_idx] == lookup_tag);

   // Not-taken training keeps the entry but suppresses the prediction
   assign pred_taken = hit & taken[lookup_idx];
   assign pred_tgt   = tgt[lookup_idx];

   // Valid bits, all entries invalid after reset
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid <= '0;
      end
      else if (update)
      begin
         valid[update_idx] <= 1'b1;
      end
   end

   // Entry payload, written on the update edge
   // Lookup in the following cycle already sees it
   always_ff @(posedge clk)
   begin
      if (update)
      begin
         tag[update_idx]   <= update_tag;
         tgt[update_idx]   <= update_tgt;
         taken[update_idx] <= update_taken;
      end
   end

endmodule

`default_nettype wire

//--- rtl/fetch_outstanding_fifo.sv
// First-word-fall-through FIFO that tracks accepted bus requests; set DW and DEPTH_LOG2 per use
`timescale 1ns/1ps
`default_nettype none

module fetch_outstanding_fifo #(
   parameter int DW         = 8,
   parameter int DEPTH_LOG2 = 2
) (
   input  wire                 clk,
   input  wire                 rst_n,
   // Write side
   input  wire                 push,
   input  wire [DW-1:0]        din,
   // Read side, head entry always visible on dout
   input  wire                 pop,
   output logic [DW-1:0]       dout,
   // Occupancy flags
   output logic                full,
   output logic                empty,
   output logic                two_left
);

   // Payload storage
   logic [DW-1:0]         mem [1 << DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   // One extra bit so a full buffer is distinct from an empty one
   logic [DEPTH_LOG2:0]   count;
   logic                  do_push;
   logic                  do_pop;

   // Ignore writes when full and reads when empty
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the count alone
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Fall-through read of the oldest entry
   assign dout = mem[rd_ptr];

   assign empty = (count == '0);
   // MSB set only when count equals the depth
   assign full  = count[DEPTH_LOG2];
   // Next pop leaves a single entry
   assign two_left = (count == (DEPTH_LOG2 + 1)'(2));

endmodule

`default_nettype wire

//--- rtl/fetch_pkg.sv
// Widths, reset vector, buffer sizes and types shared by every fetch front-end module
`default_nettype none

package fetch_pkg;

   // Byte address and instruction widths
   localparam int ADDR_W = 32;
   localparam int INSN_W = 32;
   // Word PC drops the two byte-offset bits
   localparam int PC_W = ADDR_W - 2;

   // Outstanding buffer of 4 requests
   localparam int OUTST_DEPTH_LOG2 = 2;

   // Direct-mapped predictor, 16 entries
   localparam int BTB_INDEX_W = 4;
   localparam int BTB_ENTRIES = 1 << BTB_INDEX_W;
   // Tag keeps the PC bits above the index
   localparam int BTB_TAG_W = PC_W - BTB_INDEX_W;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [PC_W-1:0]   pc_t;
   typedef logic [INSN_W-1:0] insn_t;
   // Bit 0 page fault, bit 1 bus error
   typedef logic [1:0]        bus_exc_t;
   // Interrupt request sits above the two bus bits
   typedef logic [2:0]        fetch_exc_t;

   // First word fetched after reset, byte address 0x100
   localparam pc_t RESET_VECTOR = 30'h0000_0040;

   // Buffer entry is fetch PC, predicted-taken bit and predicted next PC
   localparam int OUTST_DW = PC_W + 1 + PC_W;

   // Flush progress of the fetch unit
   typedef enum logic [1:0] {
      flush_idle,
      flush_pending,
      flush_draining
   } flush_state_e;

endpackage

`default_nettype wire

//--- rtl/fetch_unit.sv
// Fetch PC generation, instruction bus requests, response pairing and flush control for dispatch
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
   input  wire                        clk,
   input  wire                        rst_n,
   // Instruction bus, request channel
   output logic                       ibus_avalid,
   input  wire                        ibus_aready,
   output fetch_pkg::addr_t           ibus_aaddr,
   // Instruction bus, response channel
   input  wire                        ibus_bvalid,
   output logic                       ibus_bready,
   input  wire fetch_pkg::insn_t      ibus_bdata,
   input  wire fetch_pkg::bus_exc_t   ibus_bexc,
   // Interrupt level, sampled with each response
   input  wire                        irq,
   // Redirect strobe and new target
   input  wire                        flush,
   input  wire fetch_pkg::pc_t        flush_tgt,
   // Dispatch
   input  wire                        idu_ready,
   output logic                       idu_valid,
   output fetch_pkg::insn_t           idu_insn,
   output fetch_pkg::pc_t             idu_pc,
   output fetch_pkg::fetch_exc_t      idu_exc,
   output logic                       idu_pred_taken,
   output fetch_pkg::pc_t             idu_pred_tgt,
   // Predictor
   output fetch_pkg::pc_t             bpu_lookup_pc,
   input  wire                        bpu_pred_taken,
   input  wire fetch_pkg::pc_t        bpu_pred_tgt
);

   fetch_pkg::flush_state_e      state_q;
   fetch_pkg::flush_state_e      state_d;
   fetch_pkg::pc_t               flush_tgt_q;
   // Next PC to fetch when nothing redirects
   fetch_pkg::pc_t               pc_q;
   fetch_pkg::pc_t               fetch_pc;
   fetch_pkg::pc_t               pc_seq_next;
   fetch_pkg::pc_t               pred_next;

   logic                         outst_push;
   logic                         outst_pop;
   logic [fetch_pkg::OUTST_DW-1:0] outst_din;
   logic [fetch_pkg::OUTST_DW-1:0] outst_dout;
   logic                         outst_full;
   logic                         outst_empty;
   logic                         outst_two_left;

   fetch_pkg::pc_t               head_pc;
   fetch_pkg::pc_t               head_pred_tgt;
   logic                         head_pred_taken;
   logic                         discard;
   logic                         hold_req;

   // Record of every accepted request, oldest at the head
   fetch_outstanding_fifo #(
      .DW         (fetch_pkg::OUTST_DW),
      .DEPTH_LOG2 (fetch_pkg::OUTST_DEPTH_LOG2)
   ) i_outstanding_fifo (
      .clk      (clk),
      .rst_n    (rst_n),
      .push     (outst_push),
      .din      (outst_din),
      .pop      (outst_pop),
      .dout     (outst_dout),
      .full     (outst_full),
      .empty    (outst_empty),
      .two_left (outst_two_left)
   );

   // Fetch PC priority: held flush target, live flush target, then PC register
   // A taken prediction reaches the PC register when this fetch is accepted
   assign fetch_pc = (state_q == fetch_pkg::flush_pending) ? flush_tgt_q
                   : flush ? flush_tgt
                   : pc_q;

   // Predictor looks at the word being fetched right now
   assign bpu_lookup_pc = fetch_pc;

   assign pc_seq_next = fetch_pc + 1'b1;
   assign pred_next   = bpu_pred_taken ? bpu_pred_tgt : pc_seq_next;

   // Byte address, always word aligned
   assign ibus_aaddr = {fetch_pc, 2'b00};

   // Flush request waits for a cycle with no stale response popping,
   // otherwise the drain count below could not tell stale from target
   assign hold_req = (flush | (state_q == fetch_pkg::flush_pending)) & ibus_bvalid;

   // Stop requesting when full or while stale entries drain
   assign ibus_avalid = ~outst_full & (state_q != fetch_pkg::flush_draining) & ~hold_req;

   assign outst_push = ibus_avalid & ibus_aready;
   assign outst_din  = {fetch_pc, bpu_pred_taken, pred_next};
   assign outst_pop  = ibus_bvalid & ibus_bready;
   assign {head_pc, head_pred_taken, head_pred_tgt} = outst_dout;

   // Responses from before the redirect are thrown away
   assign discard = flush | (state_q != fetch_pkg::flush_idle);

   // Dispatch handshake passes straight to the response channel
   assign ibus_bready = idu_ready | discard;
   assign idu_valid   = ibus_bvalid & ~discard;

   // Pair response with its buffer entry
   assign idu_insn       = ibus_bdata;
   assign idu_pc         = head_pc;
   assign idu_exc        = {irq, ibus_bexc};
   assign idu_pred_taken = head_pred_taken;
   assign idu_pred_tgt   = head_pred_tgt;

   // Flush FSM
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         fetch_pkg::flush_idle:
         begin
            // Target request went out behind older ones
            if (flush & outst_push & ~outst_empty)
               state_d = fetch_pkg::flush_draining;
            // Target request not yet accepted
            else if (flush & ~outst_push)
               state_d = fetch_pkg::flush_pending;
         end
         fetch_pkg::flush_pending:
         begin
            if (outst_push & outst_empty)
               state_d = fetch_pkg::flush_idle;
            else if (outst_push)
               state_d = fetch_pkg::flush_draining;
         end
         fetch_pkg::flush_draining:
         begin
            // Only the target entry is left after this pop
            if (outst_pop & outst_two_left)
               state_d = fetch_pkg::flush_idle;
         end
         default:
         begin
            state_d = fetch_pkg::flush_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= fetch_pkg::flush_idle;
         pc_q    <= fetch_pkg::RESET_VECTOR;
      end
      else
      begin
         state_q <= state_d;
         // Advance only on an accepted request
         if (outst_push)
            pc_q <= pred_next;
      end
   end

   // Target kept for retries while the request is pending
   always_ff @(posedge clk)
   begin
      if (flush & (state_q == fetch_pkg::flush_idle))
         flush_tgt_q <= flush_tgt;
   end

endmodule

`default_nettype wire

//--- rtl/insn_fetch_top.sv
// Fetch front-end top level, joins the fetch unit to its branch predictor for the core or testbench
`timescale 1ns/1ps
`default_nettype none

module insn_fetch_top (
   input  wire                      clk,
   input  wire                      rst_n,
   // Instruction bus, request channel
   output logic                     ibus_avalid,
   input  wire                      ibus_aready,
   output fetch_pkg::addr_t         ibus_aaddr,
   // Instruction bus, response channel
   input  wire                      ibus_bvalid,
   output logic                     ibus_bready,
   input  wire fetch_pkg::insn_t    ibus_bdata,
   input  wire fetch_pkg::bus_exc_t ibus_bexc,
   // Interrupt and redirect
   input  wire                      irq,
   input  wire                      flush,
   input  wire fetch_pkg::pc_t      flush_tgt,
   // Dispatch
   input  wire                      idu_ready,
   output logic                     idu_valid,
   output fetch_pkg::insn_t         idu_insn,
   output fetch_pkg::pc_t           idu_pc,
   output fetch_pkg::fetch_exc_t    idu_exc,
   output logic                     idu_pred_taken,
   output fetch_pkg::pc_t           idu_pred_tgt,
   // Predictor training from execute
   input  wire                      bpu_update,
   input  wire fetch_pkg::pc_t      bpu_update_pc,
   input  wire fetch_pkg::pc_t      bpu_update_tgt,
   input  wire                      bpu_update_taken
);

   // Predictor lookup loop between the two blocks
   fetch_pkg::pc_t bpu_lookup_pc;
   logic           bpu_pred_taken;
   fetch_pkg::pc_t bpu_pred_tgt;

   // Port names match the top level one to one
   fetch_unit i_fetch_unit (.*);

   branch_target_buffer i_branch_target_buffer (
      .clk          (clk),
      .rst_n        (rst_n),
      .lookup_pc    (bpu_lookup_pc),
      .pred_taken   (bpu_pred_taken),
      .pred_tgt     (bpu_pred_tgt),
      .update       (bpu_update),
      .update_pc    (bpu_update_pc),
      .update_tgt   (bpu_update_tgt),
      .update_taken (bpu_update_taken)
   );

endmodule

`default_nettype wire

//--- verification/tb_ibus_memory.sv
// Instruction bus slave model for the fetch testbench, answers in order with words made from the PC
`timescale 1ns/1ps
`default_nettype none

module tb_ibus_memory #(
   parameter logic [31:0] INSN_XOR = 32'h0
) (
   input  wire         clk,
   input  wire         rst_n,
   // Request channel
   input  wire         avalid,
   output logic        aready,
   input  wire  [31:0] aaddr,
   // Response channel, head response held until taken
   output logic        bvalid,
   input  wire         bready,
   output logic [31:0] bdata,
   output logic [1:0]  bexc,
   // Random controls from the testbench top
   input  wire         accept_en,
   input  wire  [1:0]  resp_delay
);

   // Word PCs of accepted requests and the cycle each answer becomes due
   logic [29:0] pend_pc [$];
   int          pend_due [$];
   int          cycle;

   // Acceptance follows the random control directly
   assign aready = accept_en;

   initial
   begin
      bvalid = 1'b0;
      bdata  = '0;
      bexc   = '0;
   end

   // Handshakes take effect on the rising edge
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pend_pc.delete();
         pend_due.delete();
         cycle = 0;
      end
      else
      begin
         if (bvalid && bready)
         begin
            void'(pend_pc.pop_front());
            void'(pend_due.pop_front());
         end
         // Zero delay answers in the very next cycle
         if (avalid && aready)
         begin
            pend_pc.push_back(aaddr[31:2]);
            pend_due.push_back(cycle + int'(resp_delay));
         end
         cycle = cycle + 1;
      end
   end

   // Outputs change on the falling edge only
   always @(negedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         bvalid = 1'b0;
      end
      else if (pend_pc.size() > 0 && cycle > pend_due[0])
      begin
         bvalid = 1'b1;
         bdata  = {2'b00, pend_pc[0]} ^ INSN_XOR;
         // Page fault for every PC with bit 5 set, never a bus error
         bexc   = {1'b0, pend_pc[0][5]};
      end
      else
      begin
         bvalid = 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_insn_fetch.sv
// Testbench top for the fetch front end, random bus and dispatch traffic with flushes and training
`timescale 1ns/1ps
`default_nettype none

module tb_insn_fetch;

   // Slave answers word PC p with p xor this constant
   localparam logic [31:0] INSN_XOR = 32'hA5C3_0F96;
   // Deliveries in the two random phases, plus margin for the directed part
   localparam int RANDOM_LEN_A = 600;
   localparam int RANDOM_LEN_B = 400;
   localparam int TEST_LEN = RANDOM_LEN_A + RANDOM_LEN_B + 200;
   // At most 10 cycles of 20 ns per instruction
   localparam int WATCHDOG_NS = TEST_LEN * 10 * 20;
   // Trained branch, well away from the random flush targets
   localparam fetch_pkg::pc_t BR_PC  = 30'h0000_2005;
   localparam fetch_pkg::pc_t BR_TGT = 30'h0000_3100;

   logic                  clk = 1'b0;
   logic                  rst_n;
   logic                  ibus_avalid, ibus_aready, ibus_bvalid, ibus_bready;
   fetch_pkg::addr_t      ibus_aaddr;
   fetch_pkg::insn_t      ibus_bdata, idu_insn;
   fetch_pkg::bus_exc_t   ibus_bexc;
   logic                  irq, flush, idu_ready, idu_valid, idu_pred_taken;
   fetch_pkg::pc_t        flush_tgt, idu_pc, idu_pred_tgt;
   fetch_pkg::fetch_exc_t idu_exc;
   logic                  bpu_update, bpu_update_taken;
   fetch_pkg::pc_t        bpu_update_pc, bpu_update_tgt;
   logic                  accept_en;
   logic [1:0]            resp_delay;
   // Reference model state
   fetch_pkg::pc_t        exp_pc;
   int                    in_flight, delivered, flushes;
   logic                  flush_open;
   // Latest training, and the training that fetches after the last flush see
   logic                  ref_taken, act_taken;
   fetch_pkg::pc_t        ref_pc, ref_tgt, act_pc, act_tgt;
   // Delivery a directed step waits for
   fetch_pkg::pc_t        watch_pc;
   logic                  watch_hit;
   int                    errors = 0;
   logic [15:0]           lfsr = 16'd71;

   always #10 clk = ~clk;

   insn_fetch_top i_insn_fetch_top (.*);

   tb_ibus_memory #(.INSN_XOR(INSN_XOR)) i_ibus_memory (
      .clk        (clk),
      .rst_n      (rst_n),
      .avalid     (ibus_avalid),
      .aready     (ibus_aready),
      .aaddr      (ibus_aaddr),
      .bvalid     (ibus_bvalid),
      .bready     (ibus_bready),
      .bdata      (ibus_bdata),
      .bexc       (ibus_bexc),
      .accept_en  (accept_en),
      .resp_delay (resp_delay)
   );

   function automatic fetch_pkg::insn_t expected_insn(input fetch_pkg::pc_t pc);
      return {2'b00, pc} ^ INSN_XOR;
   endfunction

   // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
   function automatic logic [15:0] random_bits(input int n);
      logic [15:0] val;
      logic        fb;
      int          i;
      val = '0;
      for (i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         val  = {val[14:0], fb};
      end
      return val;
   endfunction

   task automatic report_error(input string msg);
      errors++;
      $display("ERR %0t ns: %s", $time, msg);
   endtask

   task automatic report_failure(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   // Expected next PC, outstanding count and flush tracking
   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         exp_pc     <= fetch_pkg::RESET_VECTOR;
         in_flight  <= 0;
         delivered  <= 0;
         flushes    <= 0;
         flush_open <= 1'b0;
         ref_taken  <= 1'b0;
         act_taken  <= 1'b0;
      end
      else
      begin
         in_flight <= in_flight + int'(ibus_avalid && ibus_aready)
                      - int'(ibus_bvalid && ibus_bready);
         // Anything older than the flush is gone, fetch restarts at the target
         if (flush)
         begin
            exp_pc     <= flush_tgt;
            flush_open <= 1'b1;
            flushes    <= flushes + 1;
            act_taken  <= ref_taken;
            act_pc     <= ref_pc;
            act_tgt    <= ref_tgt;
         end
         else if (idu_valid)
            flush_open <= 1'b0;
         if (idu_valid && idu_ready)
         begin
            exp_pc    <= idu_pred_tgt;
            delivered <= delivered + 1;
            if (idu_pc == watch_pc)
               watch_hit <= 1'b1;
         end
         if (bpu_update)
         begin
            ref_taken <= bpu_update_taken;
            ref_pc    <= bpu_update_pc;
            ref_tgt   <= bpu_update_tgt;
         end
      end
   end

   // No gap and no repeat in the delivered PC stream
   assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid && idu_ready |-> idu_pc == exp_pc)
      else report_error($sformatf("delivered pc %h, expected %h",
         $sampled(idu_pc), $sampled(exp_pc)));
   assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid |-> idu_insn == expected_insn(idu_pc))
      else report_error($sformatf("wrong instruction word for pc %h", $sampled(idu_pc)));
   // Irq level above page fault from PC bit 5
   assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid |-> idu_exc == {irq, 1'b0, idu_pc[5]})
      else report_error($sformatf("wrong exception bits for pc %h", $sampled(idu_pc)));
   // Stalled outputs hold unless a flush kills the response
   assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid && !idu_ready |=> flush || (idu_valid && $stable(idu_pc)
         && $stable(idu_insn) && $stable(idu_pred_taken) && $stable(idu_pred_tgt)))
      else report_error("dispatch outputs changed while stalled");
   assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid |-> idu_pred_taken == (act_taken && idu_pc == act_pc))
      else report_error($sformatf("wrong prediction bit for pc %h", $sampled(idu_pc)));
   // Sequential PC when not taken
   assert property (@(posedge clk) disable iff (!rst_n)
      idu_valid |-> idu_pred_tgt == (idu_pred_taken ? act_tgt : idu_pc + 1'b1))
      else report_error($sformatf("wrong predicted target for pc %h", $sampled(idu_pc)));
   assert property (@(posedge clk) disable iff (!rst_n)
      in_flight <= (1 << fetch_pkg::OUTST_DEPTH_LOG2))
      else report_error($sformatf("%0d requests outstanding", $sampled(in_flight)));

   // One falling edge of random stall, irq and optional flush stimulus
   task automatic drive_cycle(input logic allow_flush);
      @(negedge clk);
      idu_ready  = random_bits(2) != 2'b00;
      accept_en  = random_bits(2) != 2'b00;
      resp_delay = random_bits(2);
      irq        = random_bits(1) != 0;
      bpu_update = 1'b0;
      flush      = 1'b0;
      if (allow_flush && !flush_open && random_bits(5) == 0)
      begin
         flush     = 1'b1;
         flush_tgt = 30'h80 + random_bits(9);
      end
   endtask

   task automatic run_random(input int n);
      int target;
      target = delivered + n;
      while (delivered < target)
         drive_cycle(1'b1);
   endtask

   task automatic finish_flush();
      int cycles;
      cycles = 0;
      while (flush_open && cycles < 100)
      begin
         drive_cycle(1'b0);
         cycles++;
      end
      if (flush_open)
         report_failure("A flush did not complete within 100 cycles");
   endtask

   task automatic await_delivery(input fetch_pkg::pc_t pc);
      int cycles;
      watch_pc  = pc;
      watch_hit = 1'b0;
      cycles    = 0;
      while (!watch_hit && cycles < 200)
      begin
         drive_cycle(1'b0);
         cycles++;
      end
      if (!watch_hit)
         report_failure($sformatf("PC %h was never delivered", pc));
   endtask

   task automatic train_predictor(input fetch_pkg::pc_t pc, input fetch_pkg::pc_t tgt,
                                  input logic taken);
      drive_cycle(1'b0);
      bpu_update       = 1'b1;
      bpu_update_pc    = pc;
      bpu_update_tgt   = tgt;
      bpu_update_taken = taken;
      drive_cycle(1'b0);
   endtask

   task automatic redirect(input fetch_pkg::pc_t tgt);
      finish_flush();
      drive_cycle(1'b0);
      flush     = 1'b1;
      flush_tgt = tgt;
      drive_cycle(1'b0);
   endtask

   initial
   begin
      rst_n            = 1'b0;
      irq              = 1'b0;
      flush            = 1'b0;
      flush_tgt        = '0;
      idu_ready        = 1'b0;
      bpu_update       = 1'b0;
      bpu_update_taken = 1'b0;
      bpu_update_pc    = '0;
      bpu_update_tgt   = '0;
      accept_en        = 1'b0;
      resp_delay       = '0;
      watch_pc         = '0;
      watch_hit        = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      run_random(RANDOM_LEN_A);
      // Taken branch, flush lands a few words before it
      train_predictor(BR_PC, BR_TGT, 1'b1);
      redirect(BR_PC - 3);
      await_delivery(BR_PC);
      await_delivery(BR_TGT);
      // Not taken again, fetch falls through
      train_predictor(BR_PC, BR_TGT, 1'b0);
      redirect(BR_PC - 2);
      await_delivery(BR_PC);
      await_delivery(BR_PC + 1);
      run_random(RANDOM_LEN_B);
      finish_flush();
      repeat (10) drive_cycle(1'b0);
      $display("Delivered %0d instructions, %0d flushes, %0d errors",
               delivered, flushes, errors);
      if (errors == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

   // Watchdog against a stalled pipeline
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire
